// File: sources.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/commit_if.sv
hdl/rob_lookup_if.sv
hdl/register_file.sv
hdl/reorder_buffer.sv
hdl/operand_fetch.sv
hdl/rename_core.sv
tests/rename_core_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module rename_core_tb -Mdir obj_dir
	-./obj_dir/Vrename_core_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;
  import ooo_pkg::*;

  logic      clk_in = 1'b0;
  logic      rst_in = 1'b1;
  logic      issue = 1'b0;
  logic      wb_valid = 1'b0;
  logic      flush = 1'b0;
  reg_addr_t issue_rd = '0;
  reg_addr_t issue_rs1 = '0;
  reg_addr_t issue_rs2 = '0;
  rob_ix_t   wb_rob_ix = '0;
  word_t     wb_data = '0;
  logic      issue_ready;
  logic      op1_ready;
  logic      op2_ready;
  logic      commit_valid;
  rob_ix_t   issue_rob_ix;
  rob_ix_t   op1_tag;
  rob_ix_t   op2_tag;
  word_t     op1_value;
  word_t     op2_value;
  word_t     commit_data;
  reg_addr_t commit_rd;

  word_t       exp_regs [32];  // committed values as the model sees them
  rob_ix_t     exp_tail = '0;  // slot the model hands to the next issue
  logic [31:0] lfsr = 32'hc312c8a3;
  int          cycles = 0;

  rename_core dut_i (.*);

  always #2 clk_in = ~clk_in;    // 4 ns period

  // run limit far above the roughly 110 cycles of the tests
  always @(posedge clk_in) begin
    cycles++;
    if (cycles > 2000) begin
      $display("timeout: no end of test after 2000 cycles");
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1); // galois step per bit
    end
    return w;
  endfunction

  task automatic fail(string msg);
    $display("error %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_tag(rob_ix_t got, rob_ix_t exp, string what);
    if (got !== exp) fail($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_addr(reg_addr_t got, reg_addr_t exp, string what);
    if (got !== exp) fail($sformatf("%s got x%0d expected x%0d", what, got, exp));
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) fail($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // one accepted issue at the model's tail slot
  task automatic issue_op(reg_addr_t rd, output rob_ix_t ix);
    check_bit(issue_ready, 1'b1, "issue_ready before issue");
    check_tag(issue_rob_ix, exp_tail, "issue_rob_ix before issue");
    issue = 1'b1;
    issue_rd = rd;
    ix = exp_tail;
    exp_tail = exp_tail + 1'b1; // wraps with the 3-bit index
    @(negedge clk_in);
    issue = 1'b0;
  endtask

  task automatic writeback(rob_ix_t ix, word_t data);
    wb_valid = 1'b1;
    wb_rob_ix = ix;
    wb_data = data;
    @(negedge clk_in);
    wb_valid = 1'b0;
  endtask

  // waits for the next commit pulse and consumes it
  task automatic expect_commit(reg_addr_t rd, word_t data);
    while (!commit_valid) @(negedge clk_in);
    check_addr(commit_rd, rd, "commit_rd");
    check_word(commit_data, data, "commit_data");
    if (rd != 0) exp_regs[rd] = data;
    @(negedge clk_in);
  endtask

  // both sources read rs and must be ready with val
  task automatic expect_ready(reg_addr_t rs, word_t val);
    issue_rs1 = rs;
    issue_rs2 = rs;
    #1;
    check_bit(op1_ready, 1'b1, $sformatf("op1_ready for x%0d", rs));
    check_word(op1_value, val, $sformatf("op1_value for x%0d", rs));
    check_bit(op2_ready, 1'b1, $sformatf("op2_ready for x%0d", rs));
    check_word(op2_value, val, $sformatf("op2_value for x%0d", rs));
    @(negedge clk_in);
  endtask

  task automatic expect_pending(reg_addr_t rs, rob_ix_t tag);
    issue_rs1 = rs;
    issue_rs2 = rs;
    #1;
    check_bit(op1_ready, 1'b0, $sformatf("op1_ready for x%0d", rs));
    check_tag(op1_tag, tag, $sformatf("op1_tag for x%0d", rs));
    check_bit(op2_ready, 1'b0, $sformatf("op2_ready for x%0d", rs));
    check_tag(op2_tag, tag, $sformatf("op2_tag for x%0d", rs));
    @(negedge clk_in);
  endtask

  task automatic tagging_and_forwarding();
    rob_ix_t a;
    rob_ix_t z;
    word_t v;
    for (int r = 0; r < 32; r++) expect_ready(reg_addr_t'(r), '0);
    issue_op(5'd5, a);
    expect_pending(5'd5, a);
    issue_op(5'd0, z);
    expect_ready(5'd0, '0);   // x0 is never renamed
    v = rand_word();
    writeback(a, v);
    expect_ready(5'd5, v);    // forwarded before the commit
    expect_commit(5'd5, v);
    expect_ready(5'd5, exp_regs[5]);
    v = rand_word();
    writeback(z, v);
    expect_commit(5'd0, v);
  endtask

  task automatic in_order_commit();
    rob_ix_t ix [3];
    word_t v [3];
    for (int i = 0; i < 3; i++) begin
      issue_op(reg_addr_t'(i + 1), ix[i]);
      v[i] = rand_word();
    end
    for (int i = 2; i >= 0; i--) writeback(ix[i], v[i]); // youngest first
    for (int i = 0; i < 3; i++) expect_commit(reg_addr_t'(i + 1), v[i]);
  endtask

  task automatic younger_keeps_tag();
    rob_ix_t p, q;
    word_t v;
    issue_op(5'd7, p);
    issue_op(5'd7, q);
    v = rand_word();
    writeback(p, v);
    expect_commit(5'd7, v);
    expect_pending(5'd7, q);
    v = rand_word();
    writeback(q, v);
    expect_commit(5'd7, v);
    expect_ready(5'd7, exp_regs[7]);
  endtask

  task automatic full_rob();
    rob_ix_t ix [8];
    word_t v [8];
    for (int i = 0; i < 8; i++) begin
      issue_op(reg_addr_t'(i + 8), ix[i]);
      v[i] = rand_word();
    end
    check_bit(issue_ready, 1'b0, "issue_ready when full");
    issue = 1'b1;               // ninth issue must be dropped
    issue_rd = 5'd20;
    @(negedge clk_in);
    issue = 1'b0;
    check_bit(issue_ready, 1'b0, "issue_ready after dropped issue");
    check_tag(issue_rob_ix, exp_tail, "issue_rob_ix after dropped issue");
    expect_ready(5'd20, exp_regs[20]);
    writeback(ix[0], v[0]);
    expect_commit(5'd8, v[0]);
    check_bit(issue_ready, 1'b1, "issue_ready after commit");
    for (int i = 7; i >= 1; i--) writeback(ix[i], v[i]);
    for (int i = 1; i < 8; i++) expect_commit(reg_addr_t'(i + 8), v[i]);
  endtask

  task automatic flush_all();
    rob_ix_t ix [3];
    for (int i = 0; i < 3; i++) issue_op(reg_addr_t'(i + 11), ix[i]);
    writeback(ix[1], rand_word());
    writeback(ix[0], rand_word()); // head done, would retire on the flush edge
    flush = 1'b1;
    @(negedge clk_in);
    flush = 1'b0;
    exp_tail = '0;
    check_bit(issue_ready, 1'b1, "issue_ready after flush");
    check_tag(issue_rob_ix, exp_tail, "issue_rob_ix after flush");
    repeat (4) begin
      check_bit(commit_valid, 1'b0, "commit_valid after flush");
      @(negedge clk_in);
    end
    for (int i = 11; i < 14; i++) expect_ready(reg_addr_t'(i), exp_regs[i]);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) exp_regs[i] = '0;
    repeat (4) @(negedge clk_in);
    rst_in = 1'b0;
    @(negedge clk_in);
    tagging_and_forwarding();
    in_order_commit();
    younger_keeps_tag();
    full_rob();
    flush_all();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: hdl/rename_core.sv
`timescale 1ns/1ps

module rename_core (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               issue,
  input  ooo_pkg::reg_addr_t issue_rd,
  input  ooo_pkg::reg_addr_t issue_rs1,
  input  ooo_pkg::reg_addr_t issue_rs2,
  output logic               issue_ready,
  output ooo_pkg::rob_ix_t   issue_rob_ix,
  output logic               op1_ready,
  output ooo_pkg::word_t     op1_value,
  output ooo_pkg::rob_ix_t   op1_tag,
  output logic               op2_ready,
  output ooo_pkg::word_t     op2_value,
  output ooo_pkg::rob_ix_t   op2_tag,
  input  logic               wb_valid,
  input  ooo_pkg::rob_ix_t   wb_rob_ix,
  input  ooo_pkg::word_t     wb_data,
  input  logic               flush,
  output logic               commit_valid,
  output ooo_pkg::reg_addr_t commit_rd,
  output ooo_pkg::word_t     commit_data
);
  import ooo_pkg::*;

  commit_if     cm ();
  rob_lookup_if lk ();

  word_t   rval1;
  word_t   rval2;
  rob_ix_t tag1;
  rob_ix_t tag2;
  logic    busy1;
  logic    busy2;
  logic    issue_acc; // issue that the rob actually takes

  assign issue_acc = issue && issue_ready; // keeps the tag table in step when full

  register_file rf_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rs1         (issue_rs1),
    .rs2         (issue_rs2),
    .issue       (issue_acc),
    .rd          (issue_rd),
    .issue_rob_ix(issue_rob_ix),
    .cm          (cm.rf),
    .rval1       (rval1),
    .rval2       (rval2),
    .tag1        (tag1),
    .tag2        (tag2),
    .busy1       (busy1),
    .busy2       (busy2)
  );

  reorder_buffer rob_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue       (issue),
    .issue_rd    (issue_rd),
    .issue_ready (issue_ready),
    .issue_rob_ix(issue_rob_ix),
    .wb_valid    (wb_valid),
    .wb_rob_ix   (wb_rob_ix),
    .wb_data     (wb_data),
    .flush       (flush),
    .cm          (cm.rob),
    .lk          (lk.rob)
  );

  operand_fetch fetch_i (
    .rval1    (rval1),
    .rval2    (rval2),
    .tag1     (tag1),
    .tag2     (tag2),
    .busy1    (busy1),
    .busy2    (busy2),
    .lk       (lk.fetch),
    .op1_ready(op1_ready),
    .op1_value(op1_value),
    .op1_tag  (op1_tag),
    .op2_ready(op2_ready),
    .op2_value(op2_value),
    .op2_tag  (op2_tag)
  );

  // retire stream seen from outside
  assign commit_valid = cm.valid;
  assign commit_rd    = cm.rd;
  assign commit_data  = cm.data;

endmodule

// File: hdl/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
  input  ooo_pkg::word_t   rval1, // architectural values
  input  ooo_pkg::word_t   rval2,
  input  ooo_pkg::rob_ix_t tag1,  // pending writer per source
  input  ooo_pkg::rob_ix_t tag2,
  input  logic             busy1,
  input  logic             busy2,
  rob_lookup_if.fetch      lk,
  output logic             op1_ready,
  output ooo_pkg::word_t   op1_value,
  output ooo_pkg::rob_ix_t op1_tag,
  output logic             op2_ready,
  output ooo_pkg::word_t   op2_value,
  output ooo_pkg::rob_ix_t op2_tag
);

  // ask the rob about whichever entry each source waits on
  assign lk.tag1 = tag1;
  assign lk.tag2 = tag2;

  // source 1
  always_comb begin
    op1_ready = !busy1 || lk.done1;         // idle register, or writer finished
    op1_value = busy1 ? lk.value1 : rval1;  // forward from rob when still renamed
    op1_tag   = tag1;                       // only meaningful while not ready
  end

  // source 2, same rule
  always_comb begin
    op2_ready = !busy2 || lk.done2;
    op2_value = busy2 ? lk.value2 : rval2;
    op2_tag   = tag2;
  end

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reorder_buffer (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               issue,        // dropped while full
  input  ooo_pkg::reg_addr_t issue_rd,
  output logic               issue_ready,  // low when all slots are taken
  output ooo_pkg::rob_ix_t   issue_rob_ix, // slot the next issue gets
  input  logic               wb_valid,
  input  ooo_pkg::rob_ix_t   wb_rob_ix,
  input  ooo_pkg::word_t     wb_data,
  input  logic               flush,        // drops everything in flight
  commit_if.rob              cm,
  rob_lookup_if.rob          lk
);
  import ooo_pkg::*;

  localparam logic [`ROB_IX_W:0] full_count = `ROB_DEPTH;

  rob_state_t         state   [`ROB_DEPTH];
  reg_addr_t          rd_q    [`ROB_DEPTH]; // destination per slot
  word_t              value_q [`ROB_DEPTH]; // written back result per slot
  rob_ix_t            head;                 // oldest entry
  rob_ix_t            tail;                 // next free slot
  logic [`ROB_IX_W:0] count;                // one extra bit to tell full from empty

  logic issue_fire;
  logic commit_fire;
  logic hit1;
  logic hit2;

  assign issue_ready  = (count != full_count);
  assign issue_rob_ix = tail;
  assign issue_fire   = issue && issue_ready;
  assign commit_fire  = (state[head] == rob_done); // a done slot is never free so count > 0

  // control state
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      cm.valid <= 1'b0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        state[i] <= rob_free;
      end
    end else if (flush) begin
      // flush beats issue, writeback and retire of this cycle
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      cm.valid <= 1'b0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        state[i] <= rob_free;
      end
    end else begin
      cm.valid <= commit_fire; // registered pulse toward the register file
      if (commit_fire) begin
        state[head] <= rob_free;
        head        <= head + 1'b1; // wraps at depth 8
      end
      // stale writebacks to freed slots are ignored
      if (wb_valid && (state[wb_rob_ix] == rob_wait)) begin
        state[wb_rob_ix] <= rob_done;
      end
      if (issue_fire) begin
        state[tail] <= rob_wait;
        tail        <= tail + 1'b1;
      end
      case ({issue_fire, commit_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // slot payload and commit outputs
  always_ff @(posedge clk_in) begin
    if (issue_fire) begin
      rd_q[tail] <= issue_rd;
    end
    if (wb_valid) begin
      value_q[wb_rob_ix] <= wb_data;
    end
    if (commit_fire) begin
      cm.rd     <= rd_q[head];
      cm.rob_ix <= head;
      cm.data   <= value_q[head];
    end
  end

  // free slots list x0, which the register file never tags
  always_comb begin
    cm.flush = flush;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      cm.flush_addrs[i] = (state[i] != rob_free) ? rd_q[i] : '0;
    end
  end

  // lookup answers
  // the retiring slot is already free while its register write is still pending,
  // so the committed value is forwarded from the commit outputs for that cycle
  always_comb begin
    hit1      = cm.valid && (cm.rob_ix == lk.tag1);
    hit2      = cm.valid && (cm.rob_ix == lk.tag2);
    lk.done1  = (state[lk.tag1] == rob_done) || hit1;
    lk.done2  = (state[lk.tag2] == rob_done) || hit2;
    lk.value1 = hit1 ? cm.data : value_q[lk.tag1];
    lk.value2 = hit2 ? cm.data : value_q[lk.tag2];
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module register_file (
  input  logic               clk_in,
  input  logic               rst_in,
  input  ooo_pkg::reg_addr_t rs1,          // source 1 address
  input  ooo_pkg::reg_addr_t rs2,          // source 2 address
  input  logic               issue,        // accepted issue, already qualified by rob space
  input  ooo_pkg::reg_addr_t rd,           // destination of the issuing instruction
  input  ooo_pkg::rob_ix_t   issue_rob_ix, // slot allocated to it
  commit_if.rf               cm,
  output ooo_pkg::word_t     rval1,
  output ooo_pkg::word_t     rval2,
  output ooo_pkg::rob_ix_t   tag1,
  output ooo_pkg::rob_ix_t   tag2,
  output logic               busy1,
  output logic               busy2
);
  import ooo_pkg::*;

  word_t                regs [`NUM_REGS]; // committed values
  rob_ix_t              tags [`NUM_REGS]; // newest in-flight writer per register
  logic [`NUM_REGS-1:0] busy;             // set while some rob entry will write it

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
      busy <= '0;
    end else begin
      // retire, x0 stays hardwired to zero
      if (cm.valid && (cm.rd != '0)) begin
        regs[cm.rd] <= cm.data; // value always lands
        if (tags[cm.rd] == cm.rob_ix) begin
          busy[cm.rd] <= 1'b0; // only if no younger writer took the tag
        end
      end
      if (cm.flush) begin
        // every listed register loses its pending writer
        for (int j = 0; j < `ROB_DEPTH; j++) begin
          busy[cm.flush_addrs[j]] <= 1'b0;
          tags[cm.flush_addrs[j]] <= '0;
        end
      end else if (issue && (rd != '0)) begin
        // later in the block, so it beats a same-cycle retire to rd
        tags[rd] <= issue_rob_ix;
        busy[rd] <= 1'b1;
      end
    end
  end

  // read ports, state as of the last edge so the issuer never sees its own rd
  always_comb begin
    rval1 = regs[rs1];
    rval2 = regs[rs2];
    tag1  = tags[rs1];
    tag2  = tags[rs2];
    busy1 = busy[rs1];
    busy2 = busy[rs2];
  end

endmodule

// File: hdl/rob_lookup_if.sv
`timescale 1ns/1ps

interface rob_lookup_if;
  import ooo_pkg::*;

  // tags from the register file, one per source operand
  rob_ix_t tag1;
  rob_ix_t tag2;

  // answer from the rob, purely combinational
  logic  done1;
  word_t value1;
  logic  done2;
  word_t value2;

  // rob answers
  modport rob (input tag1, tag2, output done1, value1, done2, value2);

  // operand stage asks
  modport fetch (output tag1, tag2, input done1, value1, done2, value2);

endinterface

// File: hdl/commit_if.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

interface commit_if;
  import ooo_pkg::*;

  logic      valid;  // one pulse per retired entry
  reg_addr_t rd;     // destination of the retiring entry
  rob_ix_t   rob_ix; // slot it came from, compared against the stored tag
  word_t     data;   // result to write into the architectural register

  // flush side, rd of every live entry, 0 where the slot is free
  logic                       flush;
  reg_addr_t [`ROB_DEPTH-1:0] flush_addrs;

  // reorder buffer side
  modport rob (output valid, rd, rob_ix, data, flush, flush_addrs);

  // register file side
  modport rf (input valid, rd, rob_ix, data, flush, flush_addrs);

endinterface

// File: hdl/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

  // one data word as held in a register or rob entry
  typedef logic [`XLEN-1:0] word_t;

  // architectural register address, x0..x31
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

  // rob slot number, doubles as the rename tag
  typedef logic [`ROB_IX_W-1:0] rob_ix_t;

  // lifecycle of one rob entry
  typedef enum logic [1:0] {
    rob_free, // slot unallocated
    rob_wait, // issued, result not back yet
    rob_done  // result written back, waiting for its turn to commit
  } rob_state_t;

endpackage

// File: hdl/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// architectural register count, rv32 integer file
`define NUM_REGS 32

// data path width
`define XLEN 32

// reorder buffer size and index width, kept in step by hand
`define ROB_DEPTH 8
`define ROB_IX_W 3

`endif
